//--- build.f
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/inst_buffer.sv
source/reg_file.sv
source/decode.sv
source/execute.sv
source/result.sv
source/riscv_core.sv
dv/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary -j 0

SRCS := $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/core_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_tb;

   logic                  clk;
   logic                  reset;
   logic                  in_valid_i;
   pipe_pkg::fetch_word_t in_word_i;
   logic                  retire_credit_i;
   logic                  in_credit_o;
   logic                  retire_valid_o;
   pipe_pkg::retire_t     retire_o;

   // program and expected records in program order
   logic [31:0]       prog_q [$];
   string             name_q [$];
   pipe_pkg::retire_t exp_q [$];
   string             exp_name_q [$];
   int                due_q [$];

   logic [31:0] rf_m [`CORE_NREGS];
   logic [31:0] mem_m [`CORE_DMEM_WORDS];

   int errors = 0;
   int cycle = 0;
   int sent = 0;
   int retired = 0;
   int outstanding = 0;
   int credit_pulses = 0;
   int in_credits = `CORE_IN_CREDITS;
   int bp_lo = 0;
   int bp_hi = 0;
   int limit = 0;

   riscv_core u_riscv_core (
      .clk             (clk),
      .reset           (reset),
      .in_valid_i      (in_valid_i),
      .in_word_i       (in_word_i),
      .retire_credit_i (retire_credit_i),
      .in_credit_o     (in_credit_o),
      .retire_valid_o  (retire_valid_o),
      .retire_o        (retire_o)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(input logic [6:0] op, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   // RV32I arithmetic by funct3 with alt selecting sub and sra
   function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'b0, $signed(a) < $signed(b)};
         3'd3: return {31'b0, a < b};
         3'd4: return a ^ b;
         3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   // executes one instruction on the model state
   function automatic pipe_pkg::retire_t ref_step(input logic [31:0] pc,
                                                  input logic [31:0] ins);
      pipe_pkg::retire_t r;
      logic [6:0]  f7;
      logic [2:0]  f3;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] immi;
      logic [31:0] addr;
      logic        legal;
      f7    = ins[31:25];
      f3    = ins[14:12];
      a     = rf_m[ins[19:15]];
      b     = rf_m[ins[24:20]];
      immi  = {{20{ins[31]}}, ins[31:20]};
      r     = '0;
      r.valid = 1'b1;
      r.pc    = pc;
      r.rd    = ins[11:7];
      legal   = 1'b1;
      case (ins[6:0])
         7'b0110011: begin
            legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            r.data = alu_calc(f3, f7[5], a, b);
            r.wen  = 1'b1;
         end
         7'b0010011: begin
            legal  = !((f3 == 3'd1 && f7 != 7'h00) ||
                       (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20));
            r.data = alu_calc(f3, f3 == 3'd5 && f7[5], a, immi);
            r.wen  = 1'b1;
         end
         7'b0110111: begin
            r.data = {ins[31:12], 12'b0};
            r.wen  = 1'b1;
         end
         7'b0000011: begin
            legal  = (f3 == 3'd2);
            addr   = a + immi;
            r.data = mem_m[(addr >> 2) % `CORE_DMEM_WORDS];
            r.wen  = 1'b1;
         end
         7'b0100011: begin
            legal      = (f3 == 3'd2);
            addr       = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            r.data     = b;
            r.is_store = 1'b1;
            if (legal) begin
               mem_m[(addr >> 2) % `CORE_DMEM_WORDS] = b;
            end
         end
         default: legal = 1'b0;
      endcase
      if (!legal) begin
         r.illegal  = 1'b1;
         r.wen      = 1'b0;
         r.is_store = 1'b0;
      end
      if (r.wen && r.rd != 5'd0) begin
         rf_m[r.rd] = r.data;
      end
      return r;
   endfunction

   task automatic add_instr(input string name, input logic [31:0] ins);
      prog_q.push_back(ins);
      name_q.push_back(name);
   endtask

   task automatic add_random_alu(input string name, input logic [4:0] rs_lo,
                                 input logic [4:0] rs_span);
      logic [2:0] f3;
      logic       alt;
      logic [4:0] rs1;
      logic [4:0] rd;
      f3  = 3'($urandom);
      alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2 == 1);
      rs1 = rs_lo + 5'($urandom % rs_span);
      rd  = rs_lo + 5'($urandom % rs_span);
      if ($urandom % 2 == 1) begin
         add_instr(name, r_type(alt ? 7'h20 : 7'h00, rs_lo + 5'($urandom % rs_span),
                                rs1, f3, rd));
      end else if (f3 == 3'd1 || f3 == 3'd5) begin
         add_instr(name, i_type(7'b0010011, {alt ? 7'h20 : 7'h00, 5'($urandom)},
                                rs1, f3, rd));
      end else begin
         add_instr(name, i_type(7'b0010011, 12'($urandom), rs1, f3, rd));
      end
   endtask

   task automatic build_program();
      for (int i = 1; i <= 8; i++) begin
         add_instr("alu_ops", {20'($urandom), 5'(i), 7'b0110111});
         add_instr("alu_ops", i_type(7'b0010011, 12'($urandom), 5'(i), 3'd0, 5'(i)));
      end
      for (int f = 0; f < 8; f++) begin
         add_instr("alu_ops", r_type(7'h00, 5'($urandom % 8 + 1), 5'($urandom % 8 + 1),
                                     3'(f), 5'(9 + f)));
         add_instr("alu_ops", i_type(7'b0010011, (f == 1 || f == 5) ? 12'($urandom % 32)
                                     : 12'($urandom), 5'($urandom % 8 + 1), 3'(f), 5'(9 + f)));
      end
      add_instr("alu_ops", r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd17));
      add_instr("alu_ops", r_type(7'h20, 5'd3, 5'd4, 3'd5, 5'd18));
      add_instr("alu_ops", i_type(7'b0010011, 12'h40b, 5'd5, 3'd5, 5'd19));
      // writes to x0 must not stick
      add_instr("alu_ops", i_type(7'b0010011, 12'h123, 5'd1, 3'd0, 5'd0));
      add_instr("alu_ops", r_type(7'h00, 5'd0, 5'd0, 3'd6, 5'd20));
      for (int d = 1; d <= 3; d++) begin
         add_instr("forwarding", i_type(7'b0010011, 12'($urandom), 5'd1, 3'd0, 5'd21));
         for (int k = 1; k < d; k++) begin
            add_instr("forwarding", i_type(7'b0010011, 12'd7, 5'd2, 3'd0, 5'(21 + k)));
         end
         add_instr("forwarding", r_type(7'h00, 5'd21, 5'd21, 3'd0, 5'd24));
         add_instr("forwarding", r_type(7'h20, 5'd24, 5'd21, 3'd0, 5'd25));
      end
      for (int k = 0; k < 12; k++) begin
         add_random_alu("forwarding", 5'd21, 5'd5);
      end
      for (int k = 0; k < 6; k++) begin
         add_instr("load_store", i_type(7'b0010011, 12'($urandom % 64 * 4), 5'd0, 3'd0,
                                        5'd26));
         add_instr("load_store", s_type(12'd8, 5'($urandom % 8 + 1), 5'd26));
         add_instr("load_store", s_type(12'd12, 5'd21, 5'd26));
         add_instr("load_store", i_type(7'b0000011, 12'd8, 5'd26, 3'd2, 5'd27));
         // load followed at once by a use
         add_instr("load_store", r_type(7'h00, 5'd27, 5'd27, 3'd0, 5'd28));
         add_instr("load_store", i_type(7'b0000011, 12'd12, 5'd26, 3'd2, 5'd29));
         add_instr("load_store", s_type(12'd16, 5'd29, 5'd26));
      end
      add_instr("illegal", 32'hffffffff);
      add_instr("illegal", {25'h1555, 7'b1101111});
      add_instr("illegal", r_type(7'h01, 5'd2, 5'd3, 3'd0, 5'd1));
      add_instr("illegal", i_type(7'b0000011, 12'd0, 5'd0, 3'd0, 5'd2));
      add_instr("illegal", i_type(7'b0010011, 12'h401, 5'd3, 3'd1, 5'd3));
      add_instr("illegal", r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd30));
      add_instr("illegal", r_type(7'h00, 5'd3, 5'd2, 3'd0, 5'd31));
      bp_lo = prog_q.size();
      for (int k = 0; k < 30; k++) begin
         add_random_alu("credit_backpressure", 5'd1, 5'd12);
      end
      bp_hi = prog_q.size();
      for (int k = 0; k < 20; k++) begin
         add_random_alu("input_credit", 5'd1, 5'd31);
      end
   endtask

   // compares each retired record with the next expected one
   always @(posedge clk) begin
      pipe_pkg::retire_t exp_r;
      pipe_pkg::retire_t act_r;
      string             name;
      int                delay;
      #1;
      if (!reset && retire_valid_o) begin
         assert (exp_q.size() > 0) else begin
            errors++;
            $display("unexpected retire record with no instruction outstanding");
         end
         if (exp_q.size() > 0) begin
            exp_r = exp_q.pop_front();
            name  = exp_name_q.pop_front();
            act_r = retire_o;
            if (exp_r.illegal) begin
               act_r.data = exp_r.data;
            end
            assert (act_r == exp_r) else begin
               errors++;
               $display("mismatch %s: expected %h actual %h", name, exp_r, retire_o);
            end
         end
         outstanding++;
         assert (outstanding <= `CORE_OUT_CREDITS) else begin
            errors++;
            $display("more retire records outstanding than credits granted");
         end
         if (retired >= bp_lo && retired < bp_hi) begin
            delay = 15 + int'($urandom % 20);
         end else begin
            delay = int'($urandom % 6);
         end
         due_q.push_back(cycle + delay);
         retired++;
      end
   end

   initial begin
      void'($urandom(32'h1a52));
      clk             = 1'b0;
      reset           = 1'b1;
      in_valid_i      = 1'b0;
      in_word_i       = '0;
      retire_credit_i = 1'b0;
      for (int i = 0; i < `CORE_NREGS; i++) begin
         rf_m[i] = '0;
      end
      for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
         mem_m[i] = '0;
      end
      build_program();
      for (int i = 0; i < prog_q.size(); i++) begin
         exp_q.push_back(ref_step(32'(i * 4), prog_q[i]));
         exp_name_q.push_back(name_q[i]);
      end
      limit = 40 * prog_q.size() + 200;
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      while (!(sent == prog_q.size() && retired == prog_q.size()) && cycle < limit) begin
         @(posedge clk);
         cycle++;
         #2;
         if (in_credit_o) begin
            in_credits++;
            credit_pulses++;
         end
         in_valid_i = 1'b0;
         if (in_credits > 0 && sent < prog_q.size() && ($urandom % 4 != 0)) begin
            in_valid_i      = 1'b1;
            in_word_i.pc    = 32'(sent * 4);
            in_word_i.instr = prog_q[sent];
            in_credits--;
            sent++;
         end
         retire_credit_i = 1'b0;
         if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            retire_credit_i = 1'b1;
            outstanding--;
         end
      end
      // let the last input credits come back
      repeat (3) begin
         @(posedge clk);
         #2;
         in_valid_i      = 1'b0;
         retire_credit_i = 1'b0;
         if (in_credit_o) begin
            credit_pulses++;
         end
      end
      if (retired < prog_q.size()) begin
         errors++;
         $display("timeout after %0d cycles with %0d of %0d retired",
                  cycle, retired, prog_q.size());
      end
      assert (credit_pulses == sent) else begin
         errors++;
         $display("mismatch input_credit: expected %0d actual %0d", sent, credit_pulses);
      end
      $display("errors: %0d, retired %0d of %0d", errors, retired, prog_q.size());
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- source/riscv_core.sv
`timescale 1ns/1ps

module riscv_core (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid_i,
   input  pipe_pkg::fetch_word_t in_word_i,
   input  logic                  retire_credit_i,
   output logic                  in_credit_o,
   output logic                  retire_valid_o,
   output pipe_pkg::retire_t     retire_o
);

   pipe_pkg::fetch_word_t head;
   logic                  head_valid;
   logic                  take;
   logic                  freeze;
   pipe_pkg::reg_idx_t    rs1;
   pipe_pkg::reg_idx_t    rs2;
   pipe_pkg::word_t       rs1_val;
   pipe_pkg::word_t       rs2_val;
   pipe_pkg::dec_stage_t  dec;
   pipe_pkg::ex_stage_t   ex;

   inst_buffer u_inst_buffer (
      .clk          (clk),
      .reset        (reset),
      .in_valid_i   (in_valid_i),
      .in_word_i    (in_word_i),
      .take_i       (take),
      .head_o       (head),
      .head_valid_o (head_valid),
      .in_credit_o  (in_credit_o)
   );

   reg_file u_reg_file (
      .clk       (clk),
      .reset     (reset),
      .rs1_i     (rs1),
      .rs2_i     (rs2),
      .wb_i      (retire_o),
      .rs1_val_o (rs1_val),
      .rs2_val_o (rs2_val)
   );

   decode u_decode (
      .clk          (clk),
      .reset        (reset),
      .freeze_i     (freeze),
      .head_i       (head),
      .head_valid_i (head_valid),
      .rs1_val_i    (rs1_val),
      .rs2_val_i    (rs2_val),
      .take_o       (take),
      .rs1_o        (rs1),
      .rs2_o        (rs2),
      .dec_o        (dec)
   );

   // retire record doubles as the write-back forwarding source
   execute u_execute (
      .clk      (clk),
      .reset    (reset),
      .freeze_i (freeze),
      .dec_i    (dec),
      .wb_i     (retire_o),
      .ex_o     (ex)
   );

   result u_result (
      .clk             (clk),
      .reset           (reset),
      .ex_i            (ex),
      .retire_credit_i (retire_credit_i),
      .freeze_o        (freeze),
      .retire_valid_o  (retire_valid_o),
      .retire_o        (retire_o)
   );

endmodule

//--- source/result.sv
`timescale 1ns/1ps
`include "core_config.svh"

module result (
   input  logic                clk,
   input  logic                reset,
   input  pipe_pkg::ex_stage_t ex_i,
   input  logic                retire_credit_i,
   output logic                freeze_o,
   output logic                retire_valid_o,
   output pipe_pkg::retire_t   retire_o
);

   localparam int unsigned cnt_w  = $clog2(`CORE_OUT_CREDITS + 1);
   localparam int unsigned addr_w = $clog2(`CORE_DMEM_WORDS);

   pipe_pkg::word_t   dmem [`CORE_DMEM_WORDS];
   pipe_pkg::retire_t rec_q;
   logic [cnt_w-1:0]  credits;
   logic [addr_w-1:0] word_addr;
   pipe_pkg::word_t   rec_data;

   // byte offset dropped, upper bits wrap
   assign word_addr = ex_i.alu_res[addr_w+1:2];

   always_comb begin
      if (ex_i.is_load) begin
         rec_data = dmem[word_addr];
      end else if (ex_i.is_store) begin
         rec_data = ex_i.store_data;
      end else begin
         rec_data = ex_i.alu_res;
      end
   end

   // record waiting with no credit stalls the whole pipe
   assign freeze_o       = rec_q.valid && (credits == '0);
   assign retire_valid_o = rec_q.valid && (credits != '0);

   // valid here means retiring this cycle, which gates write-back
   always_comb begin
      retire_o       = rec_q;
      retire_o.valid = retire_valid_o;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
            dmem[i] <= '0;
         end
      end else if (!freeze_o && ex_i.valid && ex_i.is_store) begin
         dmem[word_addr] <= ex_i.store_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rec_q.valid <= 1'b0;
      end else if (!freeze_o) begin
         rec_q.valid    <= ex_i.valid;
         rec_q.pc       <= ex_i.pc;
         rec_q.rd       <= ex_i.rd;
         rec_q.data     <= rec_data;
         rec_q.wen      <= ex_i.wen;
         rec_q.is_store <= ex_i.is_store;
         rec_q.illegal  <= ex_i.illegal;
      end
   end

   // spend on retire, refill on returned credit
   always_ff @(posedge clk) begin
      if (reset) begin
         credits <= cnt_w'(`CORE_OUT_CREDITS);
      end else if (retire_valid_o && !retire_credit_i) begin
         credits <= credits - 1'b1;
      end else if (!retire_valid_o && retire_credit_i) begin
         credits <= credits + 1'b1;
      end
   end

endmodule

//--- source/execute.sv
`timescale 1ns/1ps
`include "core_config.svh"

module execute (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 freeze_i,
   input  pipe_pkg::dec_stage_t dec_i,
   input  pipe_pkg::retire_t    wb_i,
   output pipe_pkg::ex_stage_t  ex_o
);

   localparam int unsigned shamt_w = $clog2(`CORE_XLEN);

   pipe_pkg::word_t op_a;
   pipe_pkg::word_t rs2_fwd;
   pipe_pkg::word_t op_b;
   pipe_pkg::word_t alu_res;

   // newest producer wins: own register, then write-back, then decode
   function automatic pipe_pkg::word_t fwd(input pipe_pkg::reg_idx_t rs,
                                           input pipe_pkg::word_t    dec_val);
      if (rs == '0) begin
         return dec_val;
      end
      if (ex_o.valid && ex_o.wen && (ex_o.rd == rs)) begin
         return ex_o.alu_res;
      end
      if (wb_i.valid && wb_i.wen && (wb_i.rd == rs)) begin
         return wb_i.data;
      end
      return dec_val;
   endfunction

   always_comb begin
      op_a    = fwd(dec_i.rs1, dec_i.rs1_val);
      rs2_fwd = fwd(dec_i.rs2, dec_i.rs2_val);
      op_b    = dec_i.use_imm ? dec_i.imm : rs2_fwd;
      case (dec_i.alu_op)
         isa_pkg::alu_sub:    alu_res = op_a - op_b;
         isa_pkg::alu_and:    alu_res = op_a & op_b;
         isa_pkg::alu_or:     alu_res = op_a | op_b;
         isa_pkg::alu_xor:    alu_res = op_a ^ op_b;
         isa_pkg::alu_slt:    alu_res = pipe_pkg::word_t'($signed(op_a) < $signed(op_b));
         isa_pkg::alu_sltu:   alu_res = pipe_pkg::word_t'(op_a < op_b);
         isa_pkg::alu_sll:    alu_res = op_a << op_b[shamt_w-1:0];
         isa_pkg::alu_srl:    alu_res = op_a >> op_b[shamt_w-1:0];
         isa_pkg::alu_sra:    alu_res = $signed(op_a) >>> op_b[shamt_w-1:0];
         isa_pkg::alu_pass_b: alu_res = op_b;
         // add, also load and store addresses
         default:             alu_res = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_o.valid <= 1'b0;
      end else if (!freeze_i) begin
         ex_o.valid      <= dec_i.valid;
         ex_o.pc         <= dec_i.pc;
         ex_o.rd         <= dec_i.rd;
         ex_o.alu_res    <= alu_res;
         ex_o.store_data <= rs2_fwd;
         ex_o.is_load    <= dec_i.is_load;
         ex_o.is_store   <= dec_i.is_store;
         ex_o.wen        <= dec_i.wen;
         ex_o.illegal    <= dec_i.illegal;
      end
   end

endmodule

//--- source/decode.sv
`timescale 1ns/1ps

module decode (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  freeze_i,
   input  pipe_pkg::fetch_word_t head_i,
   input  logic                  head_valid_i,
   input  pipe_pkg::word_t       rs1_val_i,
   input  pipe_pkg::word_t       rs2_val_i,
   output logic                  take_o,
   output pipe_pkg::reg_idx_t    rs1_o,
   output pipe_pkg::reg_idx_t    rs2_o,
   output pipe_pkg::dec_stage_t  dec_o
);

   pipe_pkg::word_t      instr;
   logic [2:0]           funct3;
   logic [6:0]           funct7;
   logic                 legal;
   logic                 uses_rs1;
   logic                 uses_rs2;
   logic                 stall;
   pipe_pkg::dec_stage_t dec_d;

   assign instr  = head_i.instr;
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];
   assign rs1_o  = instr[19:15];
   assign rs2_o  = instr[24:20];

   function automatic isa_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
      case (f3)
         isa_pkg::f3_add_sub: return alt ? isa_pkg::alu_sub : isa_pkg::alu_add;
         isa_pkg::f3_sll:     return isa_pkg::alu_sll;
         isa_pkg::f3_slt:     return isa_pkg::alu_slt;
         isa_pkg::f3_sltu:    return isa_pkg::alu_sltu;
         isa_pkg::f3_xor:     return isa_pkg::alu_xor;
         isa_pkg::f3_srl_sra: return alt ? isa_pkg::alu_sra : isa_pkg::alu_srl;
         isa_pkg::f3_or:      return isa_pkg::alu_or;
         isa_pkg::f3_and:     return isa_pkg::alu_and;
         default:             return isa_pkg::alu_add;
      endcase
   endfunction

   always_comb begin
      dec_d         = '0;
      dec_d.valid   = 1'b1;
      dec_d.pc      = head_i.pc;
      dec_d.rd      = instr[11:7];
      dec_d.rs1     = rs1_o;
      dec_d.rs2     = rs2_o;
      dec_d.rs1_val = rs1_val_i;
      dec_d.rs2_val = rs2_val_i;
      dec_d.alu_op  = isa_pkg::alu_add;
      legal         = 1'b1;
      uses_rs1      = 1'b0;
      uses_rs2      = 1'b0;
      case (isa_pkg::opcode_e'(instr[6:0]))
         isa_pkg::op_reg: begin
            uses_rs1     = 1'b1;
            uses_rs2     = 1'b1;
            dec_d.wen    = 1'b1;
            dec_d.alu_op = alu_sel(funct3, funct7 == isa_pkg::f7_alt);
            // alt funct7 only for sub and sra
            legal = (funct7 == isa_pkg::f7_base) ||
                    ((funct7 == isa_pkg::f7_alt) &&
                     ((funct3 == isa_pkg::f3_add_sub) || (funct3 == isa_pkg::f3_srl_sra)));
         end
         isa_pkg::op_imm: begin
            uses_rs1      = 1'b1;
            dec_d.wen     = 1'b1;
            dec_d.use_imm = 1'b1;
            dec_d.imm     = {{20{instr[31]}}, instr[31:20]};
            dec_d.alu_op  = alu_sel(funct3,
                                    (funct3 == isa_pkg::f3_srl_sra) &&
                                    (funct7 == isa_pkg::f7_alt));
            // shift immediates constrain the upper bits
            if (funct3 == isa_pkg::f3_sll) begin
               legal = (funct7 == isa_pkg::f7_base);
            end else if (funct3 == isa_pkg::f3_srl_sra) begin
               legal = (funct7 == isa_pkg::f7_base) || (funct7 == isa_pkg::f7_alt);
            end
         end
         isa_pkg::op_lui: begin
            dec_d.wen     = 1'b1;
            dec_d.use_imm = 1'b1;
            dec_d.imm     = {instr[31:12], 12'b0};
            dec_d.alu_op  = isa_pkg::alu_pass_b;
         end
         isa_pkg::op_load: begin
            uses_rs1      = 1'b1;
            dec_d.wen     = 1'b1;
            dec_d.is_load = 1'b1;
            dec_d.use_imm = 1'b1;
            dec_d.imm     = {{20{instr[31]}}, instr[31:20]};
            legal         = (funct3 == isa_pkg::f3_word);
         end
         isa_pkg::op_store: begin
            uses_rs1       = 1'b1;
            uses_rs2       = 1'b1;
            dec_d.is_store = 1'b1;
            dec_d.use_imm  = 1'b1;
            dec_d.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            legal          = (funct3 == isa_pkg::f3_word);
         end
         default: legal = 1'b0;
      endcase
      // unknown encodings retire with no side effects
      if (!legal) begin
         dec_d.illegal  = 1'b1;
         dec_d.wen      = 1'b0;
         dec_d.is_load  = 1'b0;
         dec_d.is_store = 1'b0;
      end
   end

   // load-use against the load sitting in the decode register
   assign stall = dec_o.valid && dec_o.is_load && (dec_o.rd != '0) &&
                  ((uses_rs1 && (rs1_o == dec_o.rd)) || (uses_rs2 && (rs2_o == dec_o.rd)));

   assign take_o = head_valid_i && !stall && !freeze_i;

   // a stall or an empty buffer sends a bubble
   always_ff @(posedge clk) begin
      if (reset) begin
         dec_o.valid <= 1'b0;
      end else if (!freeze_i) begin
         dec_o       <= dec_d;
         dec_o.valid <= take_o;
      end
   end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file (
   input  logic               clk,
   input  logic               reset,
   input  pipe_pkg::reg_idx_t rs1_i,
   input  pipe_pkg::reg_idx_t rs2_i,
   input  pipe_pkg::retire_t  wb_i,
   output pipe_pkg::word_t    rs1_val_o,
   output pipe_pkg::word_t    rs2_val_o
);

   pipe_pkg::word_t regs [`CORE_NREGS];
   logic            wr_en;

   // x0 is never written
   assign wr_en = wb_i.valid && wb_i.wen && (wb_i.rd != '0);

   // a read of the register being written returns the new value
   function automatic pipe_pkg::word_t read_port(input pipe_pkg::reg_idx_t rs);
      if (rs == '0) begin
         return '0;
      end
      if (wr_en && (wb_i.rd == rs)) begin
         return wb_i.data;
      end
      return regs[rs];
   endfunction

   always_comb begin
      rs1_val_o = read_port(rs1_i);
      rs2_val_o = read_port(rs2_i);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `CORE_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb_i.rd] <= wb_i.data;
      end
   end

endmodule

//--- source/inst_buffer.sv
`timescale 1ns/1ps
`include "core_config.svh"

module inst_buffer (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  in_valid_i,
   input  pipe_pkg::fetch_word_t in_word_i,
   input  logic                  take_i,
   output pipe_pkg::fetch_word_t head_o,
   output logic                  head_valid_o,
   output logic                  in_credit_o
);

   localparam int unsigned depth = `CORE_IN_CREDITS;
   localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int unsigned cnt_w = $clog2(depth + 1);

   pipe_pkg::fetch_word_t mem [depth];
   logic [ptr_w-1:0]      wr_ptr;
   logic [ptr_w-1:0]      rd_ptr;
   logic [cnt_w-1:0]      count;

   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      if (ptr == ptr_w'(depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // sender never exceeds its credits, so no full check
   always_ff @(posedge clk) begin
      if (in_valid_i) begin
         mem[wr_ptr] <= in_word_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         in_credit_o <= 1'b0;
      end else begin
         if (in_valid_i) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (take_i) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (in_valid_i && !take_i) begin
            count <= count + 1'b1;
         end else if (!in_valid_i && take_i) begin
            count <= count - 1'b1;
         end
         // one credit back per entry handed to decode
         in_credit_o <= take_i;
      end
   end

   assign head_o       = mem[rd_ptr];
   assign head_valid_o = (count != '0);

endmodule

//--- source/pipe_pkg.sv
`include "core_config.svh"

package pipe_pkg;

   typedef logic [`CORE_XLEN-1:0]          word_t;
   typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

   // one word on the input link
   typedef struct packed {
      word_t pc;
      word_t instr;
   } fetch_word_t;

   // decode stage register
   typedef struct packed {
      logic              valid;
      word_t             pc;
      reg_idx_t          rd;
      reg_idx_t          rs1;
      reg_idx_t          rs2;
      word_t             rs1_val;
      word_t             rs2_val;
      word_t             imm;
      isa_pkg::alu_op_e  alu_op;
      logic              use_imm;
      logic              is_load;
      logic              is_store;
      logic              wen;
      logic              illegal;
   } dec_stage_t;

   // execute stage register, alu_res is the address for memory ops
   typedef struct packed {
      logic     valid;
      word_t    pc;
      reg_idx_t rd;
      word_t    alu_res;
      word_t    store_data;
      logic     is_load;
      logic     is_store;
      logic     wen;
      logic     illegal;
   } ex_stage_t;

   // retire record, also the write-back source
   typedef struct packed {
      logic     valid;
      word_t    pc;
      reg_idx_t rd;
      word_t    data;
      logic     wen;
      logic     is_store;
      logic     illegal;
   } retire_t;

endpackage

//--- source/isa_pkg.sv
package isa_pkg;

   // major opcodes the core understands
   typedef enum logic [6:0] {
      op_reg   = 7'b0110011,
      op_imm   = 7'b0010011,
      op_lui   = 7'b0110111,
      op_load  = 7'b0000011,
      op_store = 7'b0100011
   } opcode_e;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_sltu,
      alu_sll,
      alu_srl,
      alu_sra,
      // lui passes the immediate through
      alu_pass_b
   } alu_op_e;

   // funct3 field values
   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_sll     = 3'b001;
   localparam logic [2:0] f3_slt     = 3'b010;
   localparam logic [2:0] f3_sltu    = 3'b011;
   localparam logic [2:0] f3_xor     = 3'b100;
   localparam logic [2:0] f3_srl_sra = 3'b101;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;

   // lw and sw share this width code
   localparam logic [2:0] f3_word    = 3'b010;

   // funct7 field values
   localparam logic [6:0] f7_base    = 7'b0000000;
   localparam logic [6:0] f7_alt     = 7'b0100000;

endpackage

//--- include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath width and register count
`define CORE_XLEN        32
`define CORE_NREGS       32

// data memory depth in words
`define CORE_DMEM_WORDS  256

// credits on the input and retire links
`define CORE_IN_CREDITS  4
`define CORE_OUT_CREDITS 4

`endif
